/* dcache_sys.f */
hw/dcache_pkg.sv
hw/dcache_array_if.sv
hw/dcache_store.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
test/burst_mem_model.sv
test/tb_dcache.sv

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dcache_sys.f --top-module tb_dcache \
    -Mdir obj_dir -o tb_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
fi
exit $status

/* test/tb_dcache.sv */
`timescale 1ns/1ns

module tb_dcache;
    import dcache_pkg::*;

    localparam int          STALL_LIMIT = 400;
    localparam logic [31:0] MERGE_ADDR  = 32'h0000_0044;
    localparam word_t       MERGE_DATA  = 32'h1122_3344;
    localparam strb_t       MERGE_WEN   = 4'b0101;

    logic        clk;
    logic        rst;
    logic        data_en;
    logic [31:0] data_addr;
    strb_t       data_wen;
    word_t       data_wdata;
    logic        no_cache;
    word_t       data_rdata;
    logic        stall;
    logic        stress;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic        arvalid;
    logic        arready;
    word_t       rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic [7:0]  awlen;
    logic        awvalid;
    logic        awready;
    word_t       wdata;
    strb_t       wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;

    // transfer monitor
    int          ar_count = 0;
    int          ar_busy = 0;   // cycles with arvalid high
    int          aw_count = 0;
    int          w_count = 0;
    logic [31:0] last_araddr;
    logic [7:0]  last_arlen;
    logic [31:0] last_awaddr;
    logic [7:0]  last_awlen;
    strb_t       last_wstrb;

    dcache_top u_dcache_top (
        .clk(clk), .rst(rst), .data_en(data_en), .data_addr(data_addr),
        .data_wen(data_wen), .data_wdata(data_wdata), .no_cache(no_cache),
        .data_rdata(data_rdata), .stall(stall),
        .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awlen(awlen), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

    burst_mem_model u_mem (
        .clk(clk), .rst(rst), .stress(stress),
        .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (arvalid) ar_busy <= ar_busy + 1;
            if (arvalid && arready) begin
                ar_count    <= ar_count + 1;
                last_araddr <= araddr;
                last_arlen  <= arlen;
            end
            if (awvalid && awready) begin
                aw_count    <= aw_count + 1;
                last_awaddr <= awaddr;
                last_awlen  <= awlen;
            end
            if (wvalid && wready) begin
                w_count    <= w_count + 1;
                last_wstrb <= wstrb;
            end
        end
    end

    // memory preload rule
    function automatic word_t init_value(input logic [31:0] addr);
        return {addr[15:0] ^ 16'hbeef, addr[15:0]};
    endfunction

    function automatic word_t merge_lanes(input word_t old, input word_t fresh, input strb_t wen);
        word_t mask;
        mask = {{8{wen[3]}}, {8{wen[2]}}, {8{wen[1]}}, {8{wen[0]}}};
        return (old & ~mask) | (fresh & mask);
    endfunction

    function automatic logic [31:0] set3_line(input int k);
        return (32'(k) << 8) | 32'h30;   // index 3, tag k
    endfunction

    function automatic word_t set3_value(input int k);
        return 32'hd00d_0000 | 32'(k);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string test, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", test, exp, act));
        end
    endtask

    task automatic check_strb(input string test, input strb_t exp, input strb_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", test, exp, act));
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    // called 2 ns after a rising edge, returns at the same phase
    task automatic cpu_access(input string test, input logic [31:0] addr, input strb_t wen,
                              input word_t wdata, input logic unc, output word_t rd);
        int waited;
        waited     = 0;
        data_en    = 1'b1;
        data_addr  = addr;
        data_wen   = wen;
        data_wdata = wdata;
        no_cache   = unc;
        @(negedge clk);
        while (stall && waited < STALL_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (stall) begin
            abort_run($sformatf("%s: access to %h still stalled after %0d cycles",
                                test, addr, waited));
        end else begin
            rd = data_rdata;
            @(posedge clk);
            #2;
            data_en  = 1'b0;
            data_wen = '0;
            no_cache = 1'b0;
        end
    endtask

    task automatic load_word(input string test, input logic [31:0] addr, input logic unc,
                             output word_t rd);
        cpu_access(test, addr, 4'b0000, 32'h0, unc, rd);
    endtask

    task automatic store_word(input string test, input logic [31:0] addr, input strb_t wen,
                              input word_t wdata, input logic unc);
        word_t unused_rd;
        cpu_access(test, addr, wen, wdata, unc, unused_rd);
    endtask

    task automatic read_miss_then_hit();
        int    ar_before;
        int    busy_before;
        word_t rd;
        ar_before = ar_count;
        load_word("read_miss_then_hit", 32'h48, 1'b0, rd);
        check_word("read_miss_then_hit", init_value(32'h48), rd);
        check_word("read_miss_then_hit ar count", 32'd1, 32'(ar_count - ar_before));
        check_word("read_miss_then_hit araddr", 32'h40, last_araddr);
        check_word("read_miss_then_hit arlen", 32'd3, {24'd0, last_arlen});
        busy_before = ar_busy;
        load_word("read_miss_then_hit", 32'h4c, 1'b0, rd);
        check_word("read_miss_then_hit", init_value(32'h4c), rd);
        check_word("read_miss_then_hit arvalid", 32'(busy_before), 32'(ar_busy));
    endtask

    task automatic store_byte_merge();
        int    ar_before;
        int    aw_before;
        word_t rd;
        ar_before = ar_count;
        aw_before = aw_count;
        store_word("store_byte_merge", MERGE_ADDR, MERGE_WEN, MERGE_DATA, 1'b0);
        load_word("store_byte_merge", MERGE_ADDR, 1'b0, rd);
        check_word("store_byte_merge",
                   merge_lanes(init_value(MERGE_ADDR), MERGE_DATA, MERGE_WEN), rd);
        check_word("store_byte_merge ar count", 32'(ar_before), 32'(ar_count));
        check_word("store_byte_merge aw count", 32'(aw_before), 32'(aw_count));
    endtask

    task automatic dirty_eviction_plru();
        int          aw_before;
        int          w_before;
        logic [31:0] first_line;
        word_t       rd;
        for (int k = 0; k < 4; k++) begin
            store_word("dirty_eviction_plru", set3_line(k), 4'b1111, set3_value(k), 1'b0);
        end
        aw_before = aw_count;
        w_before  = w_count;
        // fill order 0, 2, 1, 3 puts the first line back under the victim pointer
        store_word("dirty_eviction_plru", set3_line(4), 4'b1111, set3_value(4), 1'b0);
        first_line = set3_line(0);
        check_word("dirty_eviction_plru aw count", 32'd1, 32'(aw_count - aw_before));
        check_word("dirty_eviction_plru awaddr", first_line, last_awaddr);
        check_word("dirty_eviction_plru awlen", 32'd3, {24'd0, last_awlen});
        check_word("dirty_eviction_plru w beats", 32'd4, 32'(w_count - w_before));
        check_word("dirty_eviction_plru memory", set3_value(0), u_mem.mem[first_line[11:2]]);
        for (int k = 0; k < 5; k++) begin
            load_word("dirty_eviction_plru", set3_line(k), 1'b0, rd);
            check_word("dirty_eviction_plru", set3_value(k), rd);
        end
    endtask

    task automatic uncached_single_beat();
        int    ar_before;
        int    aw_before;
        int    w_before;
        word_t rd;
        word_t exp;
        aw_before = aw_count;
        w_before  = w_count;
        store_word("uncached_single_beat", 32'h808, 4'b0110, 32'hcafe_f00d, 1'b1);
        check_word("uncached_single_beat aw count", 32'd1, 32'(aw_count - aw_before));
        check_word("uncached_single_beat awaddr", 32'h808, last_awaddr);
        check_word("uncached_single_beat awlen", 32'd0, {24'd0, last_awlen});
        check_word("uncached_single_beat w beats", 32'd1, 32'(w_count - w_before));
        check_strb("uncached_single_beat wstrb", 4'b0110, last_wstrb);
        exp       = merge_lanes(init_value(32'h808), 32'hcafe_f00d, 4'b0110);
        ar_before = ar_count;
        load_word("uncached_single_beat", 32'h808, 1'b1, rd);
        check_word("uncached_single_beat", exp, rd);
        check_word("uncached_single_beat ar count", 32'd1, 32'(ar_count - ar_before));
        check_word("uncached_single_beat araddr", 32'h808, last_araddr);
        check_word("uncached_single_beat arlen", 32'd0, {24'd0, last_arlen});
        // memory still has the stale copy of the dirty cached word
        load_word("uncached_single_beat", MERGE_ADDR, 1'b1, rd);
        check_word("uncached_single_beat", init_value(MERGE_ADDR), rd);
        ar_before = ar_count;
        load_word("uncached_single_beat", MERGE_ADDR, 1'b0, rd);
        check_word("uncached_single_beat",
                   merge_lanes(init_value(MERGE_ADDR), MERGE_DATA, MERGE_WEN), rd);
        check_word("uncached_single_beat ar count", 32'(ar_before), 32'(ar_count));
    endtask

    task automatic backpressure_consistency();
        stress = 1'b1;
        apply_reset();
        read_miss_then_hit();
        store_byte_merge();
        dirty_eviction_plru();
    endtask

    initial begin
        rst        = 1'b1;
        data_en    = 1'b0;
        data_addr  = '0;
        data_wen   = '0;
        data_wdata = '0;
        no_cache   = 1'b0;
        stress     = 1'b0;
        apply_reset();
        read_miss_then_hit();
        store_byte_merge();
        dirty_eviction_plru();
        uncached_single_beat();
        backpressure_consistency();
        $display("Everything OK");
        $finish;
    end

endmodule

/* test/burst_mem_model.sv */
`timescale 1ns/1ns

module burst_mem_model (
    input  logic              clk,
    input  logic              rst,
    input  logic              stress,   // random ready and valid delays
    input  logic [31:0]       araddr,
    input  logic [7:0]        arlen,
    input  logic              arvalid,
    output logic              arready,
    output dcache_pkg::word_t rdata,
    output logic              rlast,
    output logic              rvalid,
    input  logic              rready,
    input  logic [31:0]       awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  dcache_pkg::word_t wdata,
    input  dcache_pkg::strb_t wstrb,
    input  logic              wlast,
    input  logic              wvalid,
    output logic              wready,
    output logic              bvalid,
    input  logic              bready
);
    import dcache_pkg::*;

    localparam int MEM_WORDS = 1024;

    word_t       mem [MEM_WORDS];
    integer      seed = 45487;
    logic [31:0] rnd;
    logic [31:0] rd_addr;
    logic [7:0]  rd_left;     // beats after the current one
    logic        rd_active;
    logic [31:0] wr_addr;
    logic        wr_active;
    logic        w_done;
    logic        go_ar;
    logic        go_r;
    logic        go_aw;
    logic        go_w;
    logic        go_b;

    function automatic word_t init_word(input logic [31:0] addr);
        return {addr[15:0] ^ 16'hbeef, addr[15:0]};
    endfunction

    always @(posedge clk) begin
        rnd <= $random(seed);
    end

    // each channel moves on three cycles out of four under stress
    assign go_ar = !stress || (rnd[1:0] != 2'b00);
    assign go_r  = !stress || (rnd[3:2] != 2'b00);
    assign go_aw = !stress || (rnd[5:4] != 2'b00);
    assign go_w  = !stress || (rnd[7:6] != 2'b00);
    assign go_b  = !stress || (rnd[9:8] != 2'b00);

    assign rdata = mem[rd_addr[11:2]];
    assign rlast = rd_left == 8'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            rd_active <= 1'b0;
            rd_addr   <= '0;
            rd_left   <= '0;
        end else if (!rd_active) begin
            if (arvalid && arready) begin
                rd_addr   <= araddr;
                rd_left   <= arlen;
                rd_active <= 1'b1;
                arready   <= 1'b0;
            end else begin
                arready <= go_ar;
            end
        end else if (rvalid && rready) begin
            if (rlast) begin
                rd_active <= 1'b0;
                rvalid    <= 1'b0;
            end else begin
                rd_addr <= rd_addr + 32'd4;
                rd_left <= rd_left - 8'd1;
                rvalid  <= go_r;
            end
        end else if (!rvalid) begin
            rvalid <= go_r;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= init_word(32'(i) << 2);
            end
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            wr_active <= 1'b0;
            w_done    <= 1'b0;
            wr_addr   <= '0;
        end else if (!wr_active) begin
            if (awvalid && awready) begin
                wr_addr   <= awaddr;
                wr_active <= 1'b1;
                awready   <= 1'b0;
            end else begin
                awready <= go_aw;
            end
        end else if (!w_done) begin
            if (wvalid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) begin
                        mem[wr_addr[11:2]][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
                wr_addr <= wr_addr + 32'd4;
                w_done  <= wlast;
                wready  <= !wlast && go_w;
            end else begin
                wready <= go_w;
            end
        end else if (bvalid && bready) begin
            bvalid    <= 1'b0;
            w_done    <= 1'b0;
            wr_active <= 1'b0;
        end else begin
            bvalid <= bvalid || go_b;
        end
    end

endmodule

/* hw/dcache_top.sv */
`timescale 1ns/1ns

module dcache_top (
    input  logic        clk,
    input  logic        rst,
    // cpu side
    input  logic        data_en,
    input  logic [31:0] data_addr,
    input  logic [3:0]  data_wen,
    input  logic [31:0] data_wdata,
    input  logic        no_cache,
    output logic [31:0] data_rdata,
    output logic        stall,
    // memory side
    output logic [31:0] araddr,
    output logic [7:0]  arlen,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready,
    output logic [31:0] awaddr,
    output logic [7:0]  awlen,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready
);

    dcache_array_if u_arr ();

    dcache_store u_store (
        .clk        (clk),
        .rst        (rst),
        .data_addr  (data_addr),
        .data_wen   (data_wen),
        .data_wdata (data_wdata),
        .arr        (u_arr.store)
    );

    dcache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .data_en    (data_en),
        .no_cache   (no_cache),
        .data_wen   (data_wen),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .stall      (stall),
        .arr        (u_arr.ctrl),
        .araddr     (araddr),
        .arlen      (arlen),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wlast      (wlast),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready)
    );

endmodule

/* hw/dcache_ctrl.sv */
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     data_en,
    input  logic                     no_cache,
    input  dcache_pkg::strb_t        data_wen,
    input  dcache_pkg::dcache_addr_u data_addr,
    input  dcache_pkg::word_t        data_wdata,
    output dcache_pkg::word_t        data_rdata,
    output logic                     stall,
    dcache_array_if.ctrl             arr,
    output logic [31:0]              araddr,
    output logic [7:0]               arlen,
    output logic                     arvalid,
    input  logic                     arready,
    input  dcache_pkg::word_t        rdata,
    input  logic                     rlast,
    input  logic                     rvalid,
    output logic                     rready,
    output logic [31:0]              awaddr,
    output logic [7:0]               awlen,
    output logic                     awvalid,
    input  logic                     awready,
    output dcache_pkg::word_t        wdata,
    output dcache_pkg::strb_t        wstrb,
    output logic                     wlast,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic                     bvalid,
    output logic                     bready
);
    import dcache_pkg::*;

    localparam logic [2:0] S_LOOKUP   = 3'd0;
    localparam logic [2:0] S_WB_ADDR  = 3'd1;
    localparam logic [2:0] S_WB_DATA  = 3'd2;
    localparam logic [2:0] S_WB_RESP  = 3'd3;
    localparam logic [2:0] S_RF_ADDR  = 3'd4;
    localparam logic [2:0] S_RF_DATA  = 3'd5;
    localparam logic [2:0] S_UNCACHED = 3'd6;

    logic [2:0]   state;
    logic [2:0]   next_state;
    word_idx_t    cnt;          // beat within a line burst
    logic         unc_addr_ok;
    logic         unc_data_ok;
    logic         unc_fin;
    word_t        unc_rdata;
    logic         uncached;
    logic         is_store;
    logic         cache_hit;
    logic [7:0]   burst_len;
    dcache_addr_u line_addr;
    dcache_addr_u wb_addr;
    logic         ar_hs, r_hs, aw_hs, w_hs, b_hs;

    assign uncached  = state == S_UNCACHED;
    assign is_store  = |data_wen;
    assign cache_hit = (state == S_LOOKUP) && data_en && !no_cache && arr.hit;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;

    always_comb begin
        line_addr              = data_addr;
        line_addr.fld.word_off = '0;
        line_addr.fld.byte_off = '0;
        wb_addr                = line_addr;
        wb_addr.fld.tag        = arr.victim_tag;
    end

    always_comb begin
        next_state = state;
        case (state)
            S_LOOKUP: begin
                if (data_en && no_cache) begin
                    next_state = S_UNCACHED;
                end else if (data_en && !arr.hit) begin
                    next_state = arr.victim_dirty ? S_WB_ADDR : S_RF_ADDR;
                end
            end
            S_WB_ADDR:  if (aw_hs) next_state = S_WB_DATA;
            S_WB_DATA:  if (w_hs && wlast) next_state = S_WB_RESP;
            S_WB_RESP:  if (b_hs) next_state = S_RF_ADDR;
            S_RF_ADDR:  if (ar_hs) next_state = S_RF_DATA;
            S_RF_DATA:  if (r_hs && rlast) next_state = S_LOOKUP;
            S_UNCACHED: if (unc_fin) next_state = S_LOOKUP;
            default:    next_state = S_LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_LOOKUP;
            cnt         <= '0;
            unc_addr_ok <= 1'b0;
            unc_data_ok <= 1'b0;
            unc_fin     <= 1'b0;
        end else begin
            state <= next_state;
            if ((state == S_WB_DATA && w_hs) || (state == S_RF_DATA && r_hs)) begin
                cnt <= cnt + word_idx_t'(1);   // wraps back to 0 after the last beat
            end
            if (uncached && !unc_fin) begin
                if (ar_hs || aw_hs) unc_addr_ok <= 1'b1;
                if (w_hs) unc_data_ok <= 1'b1;
                if (r_hs || b_hs) unc_fin <= 1'b1;
            end else begin
                unc_addr_ok <= 1'b0;
                unc_data_ok <= 1'b0;
                unc_fin     <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (uncached && r_hs) begin
            unc_rdata <= rdata;
        end
    end

    always_comb begin
        case (state)
            S_LOOKUP:   stall = data_en && (no_cache || !arr.hit);
            S_UNCACHED: stall = !unc_fin;   // one release cycle after the last transfer
            default:    stall = 1'b1;
        endcase
    end

    assign data_rdata = uncached ? unc_rdata : arr.hit_word;

    assign burst_len = uncached ? 8'd0 : 8'(LINE_WORDS - 1);

    assign arvalid = (state == S_RF_ADDR) || (uncached && !is_store && !unc_addr_ok);
    assign araddr  = uncached ? data_addr.raw : line_addr.raw;
    assign arlen   = burst_len;
    assign rready  = (state == S_RF_DATA) || (uncached && !is_store && unc_addr_ok && !unc_fin);

    assign awvalid = (state == S_WB_ADDR) || (uncached && is_store && !unc_addr_ok);
    assign awaddr  = uncached ? data_addr.raw : wb_addr.raw;
    assign awlen   = burst_len;
    assign wvalid  = (state == S_WB_DATA) || (uncached && is_store && unc_addr_ok && !unc_data_ok);
    assign wdata   = uncached ? data_wdata : arr.victim_word;
    assign wstrb   = uncached ? data_wen : '1;
    assign wlast   = uncached || (cnt == word_idx_t'(LINE_WORDS - 1));
    assign bready  = (state == S_WB_RESP) || (uncached && is_store && unc_data_ok && !unc_fin);

    // refill data goes into the victim way
    assign arr.fill_we   = (state == S_RF_DATA) && r_hs;
    assign arr.fill_idx  = cnt;
    assign arr.fill_data = rdata;
    assign arr.wb_idx    = cnt;
    assign arr.lru_touch = cache_hit;
    assign arr.store_we  = cache_hit && is_store;

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen));

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen));

    // every line burst starts at beat 0, so wlast lands on the fourth W beat
    a_beat_start: assert property (@(posedge clk) disable iff (rst)
        (aw_hs && state == S_WB_ADDR) || (ar_hs && state == S_RF_ADDR) |=> cnt == '0);

    a_refill_hits: assert property (@(posedge clk) disable iff (rst)
        state == S_RF_DATA && r_hs && rlast |=> arr.hit && arr.hit_way == $past(arr.victim_way));

endmodule

/* hw/dcache_store.sv */
`timescale 1ns/1ns

module dcache_store (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_pkg::dcache_addr_u data_addr,
    input  dcache_pkg::strb_t        data_wen,
    input  dcache_pkg::word_t        data_wdata,
    dcache_array_if.store            arr
);
    import dcache_pkg::*;

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0]   tag_arr   [WAY_NUM][SETS];
    logic [WAY_NUM-1:0] valid_arr [SETS];
    logic [WAY_NUM-1:0] dirty_arr [SETS];
    word_t              data_arr  [WAY_NUM][SETS][LINE_WORDS];
    logic [2:0]         plru      [SETS];   // tree bits per set

    logic [INDEX_W-1:0] idx;
    word_idx_t          woff;
    logic [WAY_NUM-1:0] hit_mask;
    logic [2:0]         tree;
    way_t               vway;
    word_t              merged;
    logic               fill_last;

    assign idx  = data_addr.fld.index;
    assign woff = data_addr.fld.word_off;
    assign tree = plru[idx];

    always_comb begin
        arr.hit_way = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            hit_mask[w] = valid_arr[idx][w] && (tag_arr[w][idx] == data_addr.fld.tag);
            if (hit_mask[w]) begin
                arr.hit_way = way_t'(w);
            end
        end
    end

    assign arr.hit      = |hit_mask;
    assign arr.hit_word = data_arr[arr.hit_way][idx][woff];

    // bit0 picks the half, then bit1 or bit2 inside it
    assign vway = {tree[0], tree[0] ? tree[2] : tree[1]};

    assign arr.victim_way   = vway;
    assign arr.victim_dirty = valid_arr[idx][vway] && dirty_arr[idx][vway];
    assign arr.victim_tag   = tag_arr[vway][idx];
    assign arr.victim_word  = data_arr[vway][idx][arr.wb_idx];

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = data_wen[b] ? data_wdata[8*b +: 8] : arr.hit_word[8*b +: 8];
        end
    end

    assign fill_last = arr.fill_we && (arr.fill_idx == word_idx_t'(LINE_WORDS - 1));

    // line contents and tags
    always_ff @(posedge clk) begin
        if (arr.fill_we) begin
            data_arr[vway][idx][arr.fill_idx] <= arr.fill_data;
        end
        if (fill_last) begin
            tag_arr[vway][idx] <= data_addr.fld.tag;
        end
        if (arr.store_we) begin
            data_arr[arr.hit_way][idx][woff] <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_arr[s] <= '0;
                dirty_arr[s] <= '0;
                plru[s]      <= '0;
            end
        end else begin
            if (fill_last) begin
                valid_arr[idx][vway] <= 1'b1;
                dirty_arr[idx][vway] <= 1'b0;   // fresh line from memory
            end
            if (arr.store_we) begin
                dirty_arr[idx][arr.hit_way] <= 1'b1;
            end
            if (arr.lru_touch) begin
                plru[idx][0] <= ~arr.hit_way[1];
                if (arr.hit_way[1]) begin
                    plru[idx][2] <= ~arr.hit_way[0];
                end else begin
                    plru[idx][1] <= ~arr.hit_way[0];
                end
            end
        end
    end

    // a refill must never leave a second copy of a tag in the set
    a_one_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_mask));

endmodule

/* hw/dcache_array_if.sv */
`timescale 1ns/1ns

interface dcache_array_if;
    import dcache_pkg::*;

    // lookup results
    logic             hit;
    way_t             hit_way;
    word_t            hit_word;
    way_t             victim_way;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    word_t            victim_word;   // victim line word at wb_idx

    // update requests
    logic      fill_we;
    word_idx_t fill_idx;
    word_t     fill_data;
    logic      store_we;
    logic      lru_touch;
    word_idx_t wb_idx;

    modport store (
        output hit, hit_way, hit_word, victim_way, victim_dirty, victim_tag, victim_word,
        input  fill_we, fill_idx, fill_data, store_we, lru_touch, wb_idx
    );

    modport ctrl (
        input  hit, hit_way, hit_word, victim_way, victim_dirty, victim_tag, victim_word,
        output fill_we, fill_idx, fill_data, store_we, lru_touch, wb_idx
    );

endinterface

/* hw/dcache_pkg.sv */
package dcache_pkg;

    localparam int TAG_W      = 24;
    localparam int INDEX_W    = 4;
    localparam int OFFSET_W   = 4;   // byte offset within a line
    localparam int WAY_NUM    = 4;
    localparam int LINE_WORDS = 4;   // also the burst length

    typedef logic [1:0]  way_t;
    typedef logic [1:0]  word_idx_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // cached lookup view of an address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        word_idx_t           word_off;
        logic [OFFSET_W-3:0] byte_off;
    } dcache_addr_s;

    // raw word for memory and uncached use, fields for lookup
    typedef union packed {
        logic [31:0]  raw;
        dcache_addr_s fld;
    } dcache_addr_u;

endpackage
